// ==== source/bt_pkt_params.svh ====
`ifndef BT_PKT_PARAMS_SVH
`define BT_PKT_PARAMS_SVH

// clk_6M cycles in one 625 us slot
`define BT_SLOT_CYCLES 3750

// payload length register, in bytes
`define BT_PYLEN_W 10

// payload bit count, length times eight
`define BT_PYBIT_W 13

// occupied slot count (1, 3 or 5)
`define BT_SLOTS_W 3

`endif

// ==== source/bt_pkt_pkg.sv ====
`include "bt_pkt_params.svh"

package bt_pkt_pkg;

  // packet type codes as carried in the packet header
  typedef enum logic [3:0] {
    NULL_T = 4'h0,
    POLL   = 4'h1,
    FHS    = 4'h2,
    DM1    = 4'h3,
    DH1    = 4'h4,  // also 2-DH1
    HV1    = 4'h5,
    HV2    = 4'h6,  // also 2-EV3
    HV3    = 4'h7,  // also EV3, 3-EV3
    DV     = 4'h8,  // also 3-DH1
    AUX1   = 4'h9,
    DM3    = 4'ha,  // also 2-DH3
    DH3    = 4'hb,  // also 3-DH3
    EV4    = 4'hc,  // also 2-EV5
    EV5    = 4'hd,  // also 3-EV5
    DM5    = 4'he,  // also 2-DH5
    DH5    = 4'hf   // also 3-DH5
  } pkt_type_e;

  typedef struct packed {
    logic br_mode;  // basic rate, else EDR
    logic esco;
    logic sco;
    logic acl;
  } link_mode_t;

  typedef struct packed {
    pkt_type_e              pk_type;
    link_mode_t             mode;
    logic [`BT_PYLEN_W-1:0] payload_len;    // bytes
    logic                   data_crc_byte;  // one extra byte on the length
  } tx_request_t;

  typedef struct packed {
    logic [`BT_PYBIT_W-1:0] payload_bits;
    logic [`BT_SLOTS_W-1:0] slots;
    logic                   fec13;
    logic                   fec23;
    logic                   crc;
    logic                   br_mode;
    logic                   dpsk;
    logic                   br_single_slot;
    logic                   has_pyheader;
  } pkt_format_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_SLOT,  // request taken, waiting for slot boundary
    TX,
    RX,
    DONE        // ack raised, waiting for req to drop
  } ctrl_state_e;

endpackage

// ==== source/pkt_type_decode.sv ====
`timescale 1ns/1ns
`include "bt_pkt_params.svh"

module pkt_type_decode (
  input  bt_pkt_pkg::tx_request_t req,
  output bt_pkt_pkg::pkt_format_t fmt,
  output logic                    esco_allowed
);

  logic [`BT_PYLEN_W-1:0] len_bytes;  // length incl. optional crc byte
  logic [`BT_PYLEN_W-1:0] len_plus1;  // DV data part always carries it

  assign len_bytes = req.payload_len + {{(`BT_PYLEN_W-1){1'b0}}, req.data_crc_byte};
  assign len_plus1 = req.payload_len + 1'b1;

  always_comb
  begin
    // defaults match a DM1
    fmt.has_pyheader = 1'b1;
    fmt.fec13        = 1'b0;
    fmt.fec23        = 1'b1;
    fmt.crc          = 1'b1;
    fmt.br_mode      = 1'b1;
    fmt.dpsk         = 1'b1;
    fmt.slots        = 3'd1;
    fmt.payload_bits = {len_bytes, 3'b000};
    case (req.pk_type)
      bt_pkt_pkg::NULL_T,
      bt_pkt_pkg::POLL:
      begin
        fmt.payload_bits = 13'd0;
      end
      bt_pkt_pkg::FHS:
      begin
        fmt.payload_bits = 13'd144;
      end
      bt_pkt_pkg::DM1:
      begin
      end
      bt_pkt_pkg::DH1:
      begin
        fmt.fec23   = 1'b0;
        fmt.br_mode = req.mode.br_mode;  // 2-DH1 under EDR
      end
      bt_pkt_pkg::HV1:
      begin
        fmt.payload_bits = 13'd80;
        fmt.fec13        = 1'b1;
        fmt.fec23        = 1'b0;
        fmt.crc          = 1'b0;
        fmt.has_pyheader = 1'b0;
      end
      bt_pkt_pkg::HV2:
      begin
        fmt.has_pyheader = 1'b0;
        if (req.mode.esco)  // 2-EV3
        begin
          fmt.br_mode = 1'b0;
          fmt.fec23   = 1'b0;
        end
        else
        begin
          fmt.payload_bits = 13'd160;
          fmt.crc          = 1'b0;
        end
      end
      bt_pkt_pkg::HV3:
      begin
        fmt.has_pyheader = 1'b0;
        if (req.mode.esco && req.mode.br_mode)  // EV3
          fmt.fec23 = 1'b0;
        else if (req.mode.esco)  // 3-EV3
        begin
          fmt.crc     = 1'b0;
          fmt.br_mode = 1'b0;
          fmt.dpsk    = 1'b0;
        end
        else
        begin
          // plain SCO voice of fixed 240 bits
          fmt.fec23        = 1'b0;
          fmt.crc          = 1'b0;
          fmt.payload_bits = 13'd240;
        end
      end
      bt_pkt_pkg::DV:
      begin
        if (req.mode.sco)
          fmt.payload_bits = 13'd80 + {len_plus1, 3'b000};  // voice + data
        else
        begin
          // 3-DH1 on an ACL link
          fmt.br_mode = 1'b0;
          fmt.dpsk    = 1'b0;
          fmt.fec23   = 1'b0;
        end
      end
      bt_pkt_pkg::AUX1:
      begin
        fmt.crc = 1'b0;
      end
      bt_pkt_pkg::DM3:
      begin
        fmt.slots   = 3'd3;
        fmt.br_mode = req.mode.br_mode;
      end
      bt_pkt_pkg::DH3:
      begin
        fmt.slots   = 3'd3;
        fmt.br_mode = req.mode.br_mode;
        fmt.dpsk    = req.mode.br_mode;  // 3 Mb drops dpsk
      end
      bt_pkt_pkg::EV4:
      begin
        fmt.has_pyheader = 1'b0;
        fmt.slots        = 3'd3;
        fmt.br_mode      = req.mode.br_mode;
      end
      bt_pkt_pkg::EV5:
      begin
        fmt.has_pyheader = 1'b0;
        fmt.slots        = 3'd3;
        fmt.br_mode      = req.mode.br_mode;
        fmt.dpsk         = req.mode.br_mode;
      end
      bt_pkt_pkg::DM5:
      begin
        fmt.slots   = 3'd5;
        fmt.br_mode = req.mode.br_mode;
      end
      bt_pkt_pkg::DH5:
      begin
        fmt.slots   = 3'd5;
        fmt.br_mode = req.mode.br_mode;
        fmt.dpsk    = req.mode.br_mode;
      end
    endcase
    fmt.br_single_slot = fmt.br_mode & (fmt.slots == 3'd1);
  end

  // types that may go out on an eSCO link
  assign esco_allowed = req.pk_type inside {bt_pkt_pkg::NULL_T, bt_pkt_pkg::POLL,
                                            bt_pkt_pkg::HV2, bt_pkt_pkg::HV3,
                                            bt_pkt_pkg::EV4, bt_pkt_pkg::EV5};

endmodule

// ==== source/slot_clock.sv ====
`timescale 1ns/1ns
`include "bt_pkt_params.svh"

module slot_clock (
  input  logic clk_6M,
  input  logic rstz,
  output logic tslot_p
);

  localparam int               CNT_W  = $clog2(`BT_SLOT_CYCLES);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`BT_SLOT_CYCLES - 1);

  logic [CNT_W-1:0] cnt;
  logic             cnt_zero;

  assign cnt_zero = (cnt == '0);

  // free running, first pulse one full slot after reset
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      cnt     <= RELOAD;
      tslot_p <= 1'b0;
    end
    else
    begin
      tslot_p <= cnt_zero;
      if (cnt_zero)
        cnt <= RELOAD;
      else
        cnt <= cnt - 1'b1;
    end
  end

  // slot pulses are single cycle and never back to back
  a_tslot_gap: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    tslot_p |=> !tslot_p
  );

endmodule

// ==== source/slot_extend_track.sv ====
`timescale 1ns/1ns

module slot_extend_track (
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       tslot_p,
  input  logic       tx_first_slot,
  input  logic [2:0] slots,
  output logic       tx_extend,
  output logic       rx_extend,
  output logic       tx_end_p,
  output logic       rx_end_p
);

  logic       multi_slot;
  logic       rx_first_slot;
  logic [2:0] tx_cnt;  // slot number inside the TX period
  logic [2:0] rx_cnt;

  assign multi_slot = (slots > 3'd1);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_cnt    <= 3'd2;
      tx_extend <= 1'b0;
    end
    else
    begin
      if (tx_first_slot)
        tx_cnt <= 3'd2;
      else if (tslot_p && tx_extend)
        tx_cnt <= tx_cnt + 1'b1;
      if (tx_first_slot && tslot_p && multi_slot)
        tx_extend <= 1'b1;
      else if (tx_end_p)
        tx_extend <= 1'b0;
    end
  end

  assign tx_end_p = multi_slot ? (tslot_p & tx_extend & (slots == tx_cnt))
                               : (tslot_p & tx_first_slot);

  // first RX slot follows straight after TX ends
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_first_slot <= 1'b0;
    else if (tx_end_p)
      rx_first_slot <= 1'b1;
    else if (tslot_p)
      rx_first_slot <= 1'b0;
  end

  // rx side mirrors tx with the same slot count
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rx_cnt    <= 3'd2;
      rx_extend <= 1'b0;
    end
    else
    begin
      if (rx_first_slot)
        rx_cnt <= 3'd2;
      else if (tslot_p && rx_extend)
        rx_cnt <= rx_cnt + 1'b1;
      if (rx_first_slot && tslot_p && multi_slot)
        rx_extend <= 1'b1;
      else if (rx_end_p)
        rx_extend <= 1'b0;
    end
  end

  assign rx_end_p = multi_slot ? (tslot_p & rx_extend & (slots == rx_cnt))
                               : (tslot_p & rx_first_slot);

  a_ext_exclusive: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    !(tx_extend && rx_extend)
  );

  // period ends land on slot boundaries only
  a_end_on_slot: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    (tx_end_p || rx_end_p) |-> tslot_p
  );

endmodule

// ==== source/tx_request_ctrl.sv ====
`timescale 1ns/1ns

module tx_request_ctrl (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  logic                    tslot_p,
  input  logic                    tx_req,
  input  bt_pkt_pkg::tx_request_t req,
  input  bt_pkt_pkg::pkt_format_t fmt_next,
  input  logic                    rx_end_p,
  output logic                    tx_ack,
  output logic                    tx_first_slot,
  output bt_pkt_pkg::pkt_format_t fmt,
  output logic                    tx_busy
);

  bt_pkt_pkg::ctrl_state_e state;
  bt_pkt_pkg::tx_request_t req_q;       // request as taken in IDLE
  logic [2:0]              slots_left;  // TX slots still to go

  always_ff @(posedge clk_6M)
  begin
    if (state == bt_pkt_pkg::IDLE && tx_req)
      req_q <= req;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state         <= bt_pkt_pkg::IDLE;
      tx_ack        <= 1'b0;
      tx_first_slot <= 1'b0;
      slots_left    <= 3'd0;
      fmt           <= '0;
    end
    else
    begin
      case (state)
        bt_pkt_pkg::IDLE:
        begin
          if (tx_req)
            state <= bt_pkt_pkg::WAIT_SLOT;
        end
        bt_pkt_pkg::WAIT_SLOT:
        begin
          if (tslot_p)
          begin
            fmt           <= fmt_next;  // format frozen for the whole packet
            slots_left    <= fmt_next.slots;
            tx_first_slot <= 1'b1;
            state         <= bt_pkt_pkg::TX;
          end
        end
        bt_pkt_pkg::TX:
        begin
          if (tslot_p)
          begin
            tx_first_slot <= 1'b0;
            slots_left    <= slots_left - 1'b1;
            if (slots_left == 3'd1)
              state <= bt_pkt_pkg::RX;
          end
        end
        bt_pkt_pkg::RX:
        begin
          if (rx_end_p)
          begin
            tx_ack <= 1'b1;
            state  <= bt_pkt_pkg::DONE;
          end
        end
        bt_pkt_pkg::DONE:
        begin
          // held here until the link controller drops req
          if (!tx_req)
          begin
            tx_ack <= 1'b0;
            state  <= bt_pkt_pkg::IDLE;
          end
        end
        default:
          state <= bt_pkt_pkg::IDLE;
      endcase
    end
  end

  assign tx_busy = (state == bt_pkt_pkg::WAIT_SLOT) || (state == bt_pkt_pkg::TX) ||
                   (state == bt_pkt_pkg::RX);

  a_ack_in_done: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    tx_ack |-> (state == bt_pkt_pkg::DONE)
  );

  // link controller keeps the request stable until the handshake closes
  a_req_stable: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    (tx_req && state != bt_pkt_pkg::IDLE) |-> (req == req_q)
  );

endmodule

// ==== source/bt_pkt_slot_top.sv ====
`timescale 1ns/1ns

module bt_pkt_slot_top (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  logic                    tx_req,
  input  bt_pkt_pkg::tx_request_t req,
  output logic                    tx_ack,
  output logic                    tx_busy,
  output logic                    tx_end_p,
  output logic                    rx_end_p,
  output logic                    esco_allowed,
  output bt_pkt_pkg::pkt_format_t fmt
);

  logic                    tslot_p;
  logic                    tx_first_slot;
  logic                    tx_extend;
  logic                    rx_extend;
  bt_pkt_pkg::pkt_format_t fmt_next;  // decoded from the live request

  slot_clock u_slot_clock (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .tslot_p (tslot_p)
  );

  pkt_type_decode u_pkt_type_decode (
    .req          (req),
    .fmt          (fmt_next),
    .esco_allowed (esco_allowed)
  );

  tx_request_ctrl u_tx_request_ctrl (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .tslot_p       (tslot_p),
    .tx_req        (tx_req),
    .req           (req),
    .fmt_next      (fmt_next),
    .rx_end_p      (rx_end_p),
    .tx_ack        (tx_ack),
    .tx_first_slot (tx_first_slot),
    .fmt           (fmt),
    .tx_busy       (tx_busy)
  );

  slot_extend_track u_slot_extend_track (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .tslot_p       (tslot_p),
    .tx_first_slot (tx_first_slot),
    .slots         (fmt.slots),
    .tx_extend     (tx_extend),
    .rx_extend     (rx_extend),
    .tx_end_p      (tx_end_p),
    .rx_end_p      (rx_end_p)
  );

  // slot extension only ever runs inside a busy exchange
  a_extend_busy: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    (tx_extend || rx_extend) |-> tx_busy
  );

endmodule

// ==== test/tb_bt_pkt_tasks.svh ====
`ifndef TB_BT_PKT_TASKS_SVH
`define TB_BT_PKT_TASKS_SVH

task automatic stop_on_error(input string msg);
  $display("%s", msg);
  $display("** FAIL **");
  $fatal(1, "simulation stopped on the first error");
endtask

task automatic check_fmt(input string what, input bt_pkt_pkg::pkt_format_t got,
                         input bt_pkt_pkg::pkt_format_t exp);
  if (got !== exp)
    stop_on_error($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp)
    stop_on_error($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_count(input string what, input int got, input int exp);
  if (got != exp)
    stop_on_error($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
endtask

// payload format as the packet type table defines it
function automatic bt_pkt_pkg::pkt_format_t expected_format(input bt_pkt_pkg::tx_request_t r);
  bt_pkt_pkg::pkt_format_t f;
  bt_pkt_pkg::pkt_type_e   t;
  logic                    br;
  logic                    esco;
  logic                    is_2ev3;
  logic                    is_3ev3;
  logic                    is_3dh1;
  int                      nbytes;
  t       = r.pk_type;
  br      = r.mode.br_mode;
  esco    = r.mode.esco;
  is_2ev3 = (t == bt_pkt_pkg::HV2) && esco;
  is_3ev3 = (t == bt_pkt_pkg::HV3) && esco && !br;
  is_3dh1 = (t == bt_pkt_pkg::DV) && !r.mode.sco;
  nbytes  = int'(r.payload_len) + int'(r.data_crc_byte);
  if (t inside {bt_pkt_pkg::DM5, bt_pkt_pkg::DH5})
    f.slots = 3'd5;
  else if (t inside {bt_pkt_pkg::DM3, bt_pkt_pkg::DH3, bt_pkt_pkg::EV4, bt_pkt_pkg::EV5})
    f.slots = 3'd3;
  else
    f.slots = 3'd1;
  f.has_pyheader = !(t inside {bt_pkt_pkg::HV1, bt_pkt_pkg::HV2, bt_pkt_pkg::HV3,
                               bt_pkt_pkg::EV4, bt_pkt_pkg::EV5});
  f.fec13 = (t == bt_pkt_pkg::HV1);
  f.fec23 = !(t inside {bt_pkt_pkg::DH1, bt_pkt_pkg::HV1} || is_2ev3 || is_3dh1 ||
              (t == bt_pkt_pkg::HV3 && !is_3ev3));
  f.crc = !(t inside {bt_pkt_pkg::HV1, bt_pkt_pkg::AUX1} ||
            (t == bt_pkt_pkg::HV2 && !esco) || (t == bt_pkt_pkg::HV3 && !(esco && br)));
  if (t inside {bt_pkt_pkg::DH1, bt_pkt_pkg::DM3, bt_pkt_pkg::DH3, bt_pkt_pkg::EV4,
                bt_pkt_pkg::EV5, bt_pkt_pkg::DM5, bt_pkt_pkg::DH5})
    f.br_mode = br;  // EDR variants share the code
  else
    f.br_mode = !(is_2ev3 || is_3ev3 || is_3dh1);
  if (t inside {bt_pkt_pkg::DH3, bt_pkt_pkg::EV5, bt_pkt_pkg::DH5})
    f.dpsk = br;  // 3 Mb types
  else
    f.dpsk = !(is_3ev3 || is_3dh1);
  case (t)
    bt_pkt_pkg::NULL_T,
    bt_pkt_pkg::POLL:
      f.payload_bits = 13'd0;
    bt_pkt_pkg::FHS:
      f.payload_bits = 13'd144;
    bt_pkt_pkg::HV1:
      f.payload_bits = 13'd80;
    default:
      f.payload_bits = 13'(nbytes * 8);
  endcase
  if (t == bt_pkt_pkg::HV2 && !esco)
    f.payload_bits = 13'd160;
  if (t == bt_pkt_pkg::HV3 && !esco)
    f.payload_bits = 13'd240;
  if (t == bt_pkt_pkg::DV && r.mode.sco)
    f.payload_bits = 13'(80 + (int'(r.payload_len) + 1) * 8);  // voice plus data
  f.br_single_slot = f.br_mode && (f.slots == 3'd1);
  return f;
endfunction

function automatic logic esco_expected(input bt_pkt_pkg::pkt_type_e t);
  return t inside {bt_pkt_pkg::NULL_T, bt_pkt_pkg::POLL, bt_pkt_pkg::HV2,
                   bt_pkt_pkg::HV3, bt_pkt_pkg::EV4, bt_pkt_pkg::EV5};
endfunction

task automatic next_drive_edge();
  @(posedge clk_6M);
  #2;
endtask

task automatic start_request(input bt_pkt_pkg::tx_request_t r);
  next_drive_edge();
  req    = r;
  tx_req = 1'b1;
endtask

// slot pulse index of each end pulse counted from the first tick after the request
task automatic wait_for_ack(output int tx_idx, output int rx_idx);
  int pulses;
  int n;
  int rx_n;
  bit acked;
  pulses = 0;
  n      = 0;
  rx_n   = 0;
  acked  = 1'b0;
  tx_idx = 0;
  rx_idx = 0;
  while (!acked)
  begin
    @(negedge clk_6M);
    n++;
    if (n >= 2 && slot_mark)  // a tick on the first cycle meets IDLE
      pulses++;
    if (n == 2)
      check_bit("tx_busy after request", tx_busy, 1'b1);
    if ((tx_end_p || rx_end_p) && !slot_mark)
      stop_on_error("An end pulse came away from a slot boundary");
    if (tx_end_p)
    begin
      if (tx_idx != 0)
        stop_on_error("A second tx_end_p came within one packet");
      tx_idx = pulses;
    end
    if (rx_end_p)
    begin
      if (rx_idx != 0 || tx_idx == 0)
        stop_on_error("rx_end_p came twice or before tx_end_p");
      rx_idx = pulses;
      rx_n   = n;
    end
    if (tx_ack)
    begin
      if (rx_n == 0 || n != rx_n + 1)
        stop_on_error("tx_ack did not rise on the cycle after rx_end_p");
      acked = 1'b1;
    end
  end
endtask

task automatic release_request();
  next_drive_edge();
  tx_req = 1'b0;
  @(negedge clk_6M);
  check_bit("tx_ack before req drop is seen", tx_ack, 1'b1);
  @(negedge clk_6M);
  check_bit("tx_ack after req drop", tx_ack, 1'b0);
  check_bit("tx_busy after req drop", tx_busy, 1'b0);
endtask

// one full exchange with format and slot timing checked
task automatic run_packet(input bt_pkt_pkg::tx_request_t r, input int n_slots);
  bt_pkt_pkg::pkt_type_e t;
  int                    tx_idx;
  int                    rx_idx;
  t = r.pk_type;
  start_request(r);
  wait_for_ack(tx_idx, rx_idx);
  check_fmt($sformatf("fmt of %s mode %b", t.name(), r.mode), fmt, expected_format(r));
  check_count($sformatf("%s tx_end_p pulse", t.name()), tx_idx, n_slots + 1);
  check_count($sformatf("%s rx_end_p pulse", t.name()), rx_idx, 2 * n_slots + 1);
  release_request();
endtask

`endif

// ==== test/tb_bt_pkt_slot.sv ====
`timescale 1ns/1ns
`include "bt_pkt_params.svh"

module tb_bt_pkt_slot;

  localparam int SLOT           = `BT_SLOT_CYCLES;
  localparam int PACKETS        = 56;  // handshakes in the whole sequence plus one spare
  localparam int TIMEOUT_CYCLES = PACKETS * (2 * 5 + 2) * SLOT + 200;

  logic                    clk_6M;
  logic                    rstz;
  logic                    tx_req;
  bt_pkt_pkg::tx_request_t req;
  logic                    tx_ack;
  logic                    tx_busy;
  logic                    tx_end_p;
  logic                    rx_end_p;
  logic                    esco_allowed;
  bt_pkt_pkg::pkt_format_t fmt;
  int unsigned             slot_cyc;  // cycles since reset release
  logic                    slot_mark;  // where the DUT slot tick should be
  int unsigned             run_cycles = 0;
  int                      seed;

  bt_pkt_slot_top i_dut (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .tx_req       (tx_req),
    .req          (req),
    .tx_ack       (tx_ack),
    .tx_busy      (tx_busy),
    .tx_end_p     (tx_end_p),
    .rx_end_p     (rx_end_p),
    .esco_allowed (esco_allowed),
    .fmt          (fmt)
  );

  always #10 clk_6M = ~clk_6M;

  // first tick one full slot after reset and every slot after that
  always @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_cyc <= 0;
    else
      slot_cyc <= slot_cyc + 1;
  end

  assign slot_mark = (slot_cyc != 0) && (slot_cyc % SLOT == 0);

  always @(posedge clk_6M)
  begin
    run_cycles <= run_cycles + 1;
    if (run_cycles > TIMEOUT_CYCLES)
      stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  `include "tb_bt_pkt_tasks.svh"

  task automatic test_reset_values();
    @(negedge clk_6M);
    check_bit("tx_ack after reset", tx_ack, 1'b0);
    check_bit("tx_busy after reset", tx_busy, 1'b0);
    check_bit("tx_end_p after reset", tx_end_p, 1'b0);
    check_bit("rx_end_p after reset", rx_end_p, 1'b0);
    check_fmt("fmt after reset", fmt, '0);
  endtask

  task automatic test_format_decode();
    bt_pkt_pkg::tx_request_t r;
    bt_pkt_pkg::pkt_format_t exp;
    bt_pkt_pkg::link_mode_t  modes [3];
    modes[0] = 4'b1001;  // BR ACL
    modes[1] = 4'b1100;  // eSCO on basic rate
    modes[2] = 4'b0001;  // EDR ACL
    for (int m = 0; m < 3; m++)
    begin
      for (int t = 0; t < 16; t++)
      begin
        r.pk_type       = bt_pkt_pkg::pkt_type_e'(t);
        r.mode          = modes[m];
        r.payload_len   = 10'd27 + 10'(t);
        r.data_crc_byte = (m == 0);
        exp             = expected_format(r);
        next_drive_edge();
        req = r;  // tx_req still low
        @(negedge clk_6M);
        check_bit($sformatf("esco_allowed for type %0d", t), esco_allowed,
                  esco_expected(r.pk_type));
        run_packet(r, int'(exp.slots));
      end
    end
  endtask

  task automatic test_single_slot();
    bt_pkt_pkg::tx_request_t r;
    r = '{pk_type: bt_pkt_pkg::DM1, mode: 4'b1001, payload_len: 10'd17, data_crc_byte: 1'b0};
    run_packet(r, 1);
  endtask

  task automatic test_multi_slot();
    bt_pkt_pkg::tx_request_t r;
    r = '{pk_type: bt_pkt_pkg::DH3, mode: 4'b1001, payload_len: 10'd183, data_crc_byte: 1'b0};
    run_packet(r, 3);
    r.pk_type = bt_pkt_pkg::DM5;
    run_packet(r, 5);
  endtask

  task automatic test_handshake();
    bt_pkt_pkg::tx_request_t r;
    int                      tx_idx;
    int                      rx_idx;
    r = '{pk_type: bt_pkt_pkg::DM1, mode: 4'b1001, payload_len: 10'd10, data_crc_byte: 1'b0};
    start_request(r);
    wait_for_ack(tx_idx, rx_idx);
    check_count("held DM1 tx_end_p pulse", tx_idx, 2);
    check_count("held DM1 rx_end_p pulse", rx_idx, 3);
    // controller parks in DONE while req stays high
    repeat (3 * SLOT)
    begin
      @(negedge clk_6M);
      check_bit("tx_ack while req held", tx_ack, 1'b1);
      check_bit("tx_busy while req held", tx_busy, 1'b0);
      if (tx_end_p || rx_end_p)
        stop_on_error("An end pulse came while the controller waited in DONE");
    end
    release_request();
    r.pk_type = bt_pkt_pkg::DH1;
    run_packet(r, 1);  // next request must be taken
  endtask

  task automatic test_payload_bits();
    bt_pkt_pkg::tx_request_t r;
    int                      len;
    repeat (2)
    begin
      len = $random(seed) & 32'h1ff;
      r   = '{pk_type: bt_pkt_pkg::DM1, mode: 4'b1001, payload_len: 10'(len),
              data_crc_byte: 1'b1};
      run_packet(r, 1);
      check_count("DM1 payload bits", int'(fmt.payload_bits), (len + 1) * 8);
    end
  endtask

  initial
  begin
    clk_6M = 1'b0;
    rstz   = 1'b0;
    tx_req = 1'b0;
    req    = '0;
    seed   = 36941;
    repeat (5) @(posedge clk_6M);
    #2;
    rstz = 1'b1;
    test_reset_values();
    test_format_decode();
    test_single_slot();
    test_multi_slot();
    test_handshake();
    test_payload_bits();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== bt_pkt_slot.f ====
+incdir+source
+incdir+test
source/bt_pkt_pkg.sv
source/pkt_type_decode.sv
source/slot_clock.sv
source/slot_extend_track.sv
source/tx_request_ctrl.sv
source/bt_pkt_slot_top.sv
test/tb_bt_pkt_slot.sv

// ==== Makefile ====
TOP := tb_bt_pkt_slot

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, result from sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f bt_pkt_slot.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "\*\* PASS \*\*" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
